//--- verilog/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// registers in each file, integer and fp alike
`define NUM_REGS 32

// datapath width
`define WORD_WIDTH 32

// width of the register index fields
`define REG_ADDR_WIDTH 5

// width of the primary opcode field, bits 31..26
`define OPCODE_WIDTH 6

// width of the raw immediate field, bits 15..0
`define IMM_WIDTH 16

// integer register-register, funct field selects the operation
`define OP_RTYPE 6'h00

// integer immediate add
`define OP_ADDI 6'h08

// integer load word
`define OP_LW 6'h23

// float load word
`define OP_FLW 6'h31

// float store word, no destination register
`define OP_FSW 6'h39

`endif

//--- verilog/cpuPkg.sv
`include "cpu_defs.svh"

package cpuPkg;

    // operands, write data and extended immediates
    typedef logic [`WORD_WIDTH-1:0] wordT;

    // register index, same for both files
    typedef logic [`REG_ADDR_WIDTH-1:0] regAddrT;

    // primary opcode
    typedef logic [`OPCODE_WIDTH-1:0] opcodeT;

    // raw instruction word as fetched
    typedef logic [`WORD_WIDTH-1:0] instrT;

endpackage

//--- verilog/intRegFile.sv
`timescale 1ns/1ns
`include "cpu_defs.svh"

module intRegFile (
    input  logic            clk,
    input  logic            rstN,
    input  logic            hold,
    input  cpuPkg::regAddrT rs1Addr,
    input  cpuPkg::regAddrT rs2Addr,
    input  logic            wrEn,
    input  cpuPkg::regAddrT wrAddr,
    input  cpuPkg::wordT    wrData,
    output cpuPkg::wordT    rData1,
    output cpuPkg::wordT    rData2
);

    // register storage, entry 0 stays at its reset value
    cpuPkg::wordT regs [`NUM_REGS];

    // next values of the two read registers
    cpuPkg::wordT rdNext1;
    cpuPkg::wordT rdNext2;

    // write qualified, r0 writes dropped here
    logic wrLive;

    assign wrLive = wrEn && (wrAddr != '0);

    // read select shared by both ports
    // zero register first, then bypass, then storage
    function automatic cpuPkg::wordT portRead(input cpuPkg::regAddrT addr);
        cpuPkg::wordT val;
        if (addr == '0) begin
            val = '0;
        end else if (wrLive && (wrAddr == addr)) begin
            val = wrData;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_comb begin
        rdNext1 = portRead(rs1Addr);
        rdNext2 = portRead(rs2Addr);
    end

    // writeback side, never held by the pipeline stall
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrLive) begin
            regs[wrAddr] <= wrData;
        end
    end

    // registered read ports
    // stall freezes them so the latch and the operands stay aligned
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rData1 <= '0;
            rData2 <= '0;
        end else if (!hold) begin
            rData1 <= rdNext1;
            rData2 <= rdNext2;
        end
    end

endmodule

//--- verilog/fpRegFile.sv
`timescale 1ns/1ns
`include "cpu_defs.svh"

module fpRegFile (
    input  logic            clk,
    input  logic            rstN,
    input  logic            hold,
    input  cpuPkg::regAddrT rdAddr,
    input  logic            wrEn,
    input  cpuPkg::regAddrT wrAddr,
    input  cpuPkg::wordT    wrData,
    output cpuPkg::wordT    rData
);

    // fp storage, f0 is an ordinary register
    cpuPkg::wordT regs [`NUM_REGS];

    // next value of the read register
    cpuPkg::wordT rdNext;

    // same-cycle write to the read address goes straight through
    assign rdNext = (wrEn && (wrAddr == rdAddr)) ? wrData : regs[rdAddr];

    // writeback side, independent of hold
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // store data port
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rData <= '0;
        end else if (!hold) begin
            rData <= rdNext;
        end
    end

endmodule

//--- verilog/instrDecode.sv
`timescale 1ns/1ns
`include "cpu_defs.svh"

module instrDecode (
    input  logic            clk,
    input  logic            rstN,
    input  cpuPkg::instrT   instr,
    input  logic            instrValid,
    input  logic            stall,
    output cpuPkg::regAddrT rs1Addr,
    output cpuPkg::regAddrT rs2Addr,
    output cpuPkg::regAddrT fpSrcAddr,
    output cpuPkg::wordT    imm,
    output cpuPkg::regAddrT destAddr,
    output logic            destFp,
    output logic            destEn,
    output logic            illegal,
    output logic            outValid
);

    // raw fields
    cpuPkg::opcodeT  opcode;
    cpuPkg::regAddrT rtField;
    cpuPkg::regAddrT rdField;

    // decoded values, before the latch
    cpuPkg::wordT    immExt;
    cpuPkg::regAddrT destSel;
    logic            destFpSel;
    logic            destEnSel;
    logic            illegalSel;

    // instruction accepted this edge
    logic issue;

    assign opcode  = instr[31:26];
    assign rtField = instr[20:16];
    assign rdField = instr[15:11];

    // read addresses go straight to the register files
    assign rs1Addr   = instr[25:21];
    assign rs2Addr   = rtField;
    // fp store source shares the rt slot
    assign fpSrcAddr = rtField;

    // sign extension is the same for every opcode
    assign immExt = {{(`WORD_WIDTH-`IMM_WIDTH){instr[15]}}, instr[`IMM_WIDTH-1:0]};

    assign issue = instrValid && !stall;

    // opcode classification
    always_comb begin
        destSel    = '0;
        destFpSel  = 1'b0;
        destEnSel  = 1'b0;
        illegalSel = 1'b0;
        case (opcode)
            `OP_RTYPE: begin
                destSel   = rdField;
                // r0 as target means no write
                destEnSel = (rdField != '0);
            end
            `OP_ADDI, `OP_LW: begin
                destSel   = rtField;
                destEnSel = (rtField != '0);
            end
            `OP_FLW: begin
                // any fp register may be loaded, f0 included
                destSel   = rtField;
                destFpSel = 1'b1;
                destEnSel = 1'b1;
            end
            `OP_FSW: begin
                // store only, nothing written back
                destEnSel = 1'b0;
            end
            default: begin
                illegalSel = 1'b1;
            end
        endcase
    end

    // decode latch
    // payload loads on issue only, valid drops on an empty slot
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            imm      <= '0;
            destAddr <= '0;
            destFp   <= 1'b0;
            destEn   <= 1'b0;
            illegal  <= 1'b0;
            outValid <= 1'b0;
        end else if (!stall) begin
            outValid <= instrValid;
            if (issue) begin
                imm      <= immExt;
                destAddr <= destSel;
                destFp   <= destFpSel;
                destEn   <= destEnSel;
                illegal  <= illegalSel;
            end
        end
    end

endmodule

//--- verilog/operandFetch.sv
`timescale 1ns/1ns

module operandFetch (
    input  logic            clk,
    input  logic            rstN,
    input  cpuPkg::instrT   instr,
    input  logic            instrValid,
    input  logic            stall,
    input  logic            wbEn,
    input  logic            wbFp,
    input  cpuPkg::regAddrT wbAddr,
    input  cpuPkg::wordT    wbData,
    output cpuPkg::wordT    opA,
    output cpuPkg::wordT    opB,
    output cpuPkg::wordT    storeData,
    output cpuPkg::wordT    imm,
    output cpuPkg::regAddrT destAddr,
    output logic            destFp,
    output logic            destEn,
    output logic            illegal,
    output logic            outValid
);

    // decoder to register file addresses
    cpuPkg::regAddrT rs1Addr;
    cpuPkg::regAddrT rs2Addr;
    cpuPkg::regAddrT fpSrcAddr;

    // writeback steered to one file
    logic intWrEn;
    logic fpWrEn;

    assign intWrEn = wbEn && !wbFp;
    assign fpWrEn  = wbEn && wbFp;

    instrDecode instrDecode_i (
        .clk        (clk),
        .rstN       (rstN),
        .instr      (instr),
        .instrValid (instrValid),
        .stall      (stall),
        .rs1Addr    (rs1Addr),
        .rs2Addr    (rs2Addr),
        .fpSrcAddr  (fpSrcAddr),
        .imm        (imm),
        .destAddr   (destAddr),
        .destFp     (destFp),
        .destEn     (destEn),
        .illegal    (illegal),
        .outValid   (outValid)
    );

    // integer operands A and B
    intRegFile intRegFile_i (
        .clk     (clk),
        .rstN    (rstN),
        .hold    (stall),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .wrEn    (intWrEn),
        .wrAddr  (wbAddr),
        .wrData  (wbData),
        .rData1  (opA),
        .rData2  (opB)
    );

    // fp store operand
    fpRegFile fpRegFile_i (
        .clk    (clk),
        .rstN   (rstN),
        .hold   (stall),
        .rdAddr (fpSrcAddr),
        .wrEn   (fpWrEn),
        .wrAddr (wbAddr),
        .wrData (wbData),
        .rData  (storeData)
    );

endmodule

//--- sim/operandFetchTb.sv
`timescale 1ns/1ns
`include "cpu_defs.svh"

module operandFetchTb;

    // one row per issued instruction with the expected decode results last
    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] immF;
        logic [1:0]  wbEnFp;
        logic [4:0]  wbAddr;
        logic        stall;
        logic [2:0]  enFpIll;
        logic [4:0]  dest;
    } rowT;

    logic            clk;
    logic            rstN;
    cpuPkg::instrT   instr;
    logic            instrValid;
    logic            stall;
    logic            wbEn;
    logic            wbFp;
    cpuPkg::regAddrT wbAddr;
    cpuPkg::wordT    wbData;
    cpuPkg::wordT    opA, opB, storeData, imm;
    cpuPkg::regAddrT destAddr;
    logic            destFp, destEn, illegal, outValid;

    // shadow register files and expected latch contents
    cpuPkg::wordT    shInt [`NUM_REGS];
    cpuPkg::wordT    shFp [`NUM_REGS];
    cpuPkg::wordT    expA, expB, expS, expImm;
    cpuPkg::regAddrT expDest;
    logic            expEn, expFp, expIll, expValid, expRtype;
    logic [31:0]     rngState;
    int              errors, testErrors, testsRun, testsFailed;
    rowT             tbl [12];

    operandFetch operandFetch_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] nextRand();
        logic [31:0] x;
        x = rngState;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rngState = x;
        return x;
    endfunction

    // reads see the writeback currently driven and r0 stays zero
    function automatic cpuPkg::wordT readInt(input logic [4:0] a);
        if (a == 0) return '0;
        if (wbEn && !wbFp && wbAddr == a) return wbData;
        return shInt[a];
    endfunction

    function automatic cpuPkg::wordT readFp(input logic [4:0] a);
        if (wbEn && wbFp && wbAddr == a) return wbData;
        return shFp[a];
    endfunction

    task automatic checkVal(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %h actual %h at %0t", name, exp, act, $time);
            testErrors++;
        end
    endtask

    // drive one cycle, step the model, then check after the edge
    task automatic applyCycle(input logic [31:0] ins, input logic v, s, we, wf,
                              input logic [4:0] wa, input logic [31:0] wd,
                              input logic eEn, eFp, eIll, input logic [4:0] eDest);
        int waited;
        instr      = ins;
        instrValid = v;
        stall      = s;
        wbEn       = we;
        wbFp       = wf;
        wbAddr     = wa;
        wbData     = wd;
        if (!s) begin
            expValid = v;
            if (v) begin
                expA     = readInt(ins[25:21]);
                expB     = readInt(ins[20:16]);
                expS     = readFp(ins[20:16]);
                expImm   = {{16{ins[15]}}, ins[15:0]};
                expRtype = (ins[31:26] == `OP_RTYPE);
                expEn    = eEn;
                expFp    = eFp;
                expIll   = eIll;
                expDest  = eDest;
            end
        end
        if (we && wf) shFp[wa] = wd;
        else if (we && wa != 0) shInt[wa] = wd;
        @(posedge clk);
        #1;
        if (!expValid) begin
            checkVal("outValid", 32'h0, outValid);
        end else begin
            waited = 0;
            while (!outValid && waited < 4) begin
                @(posedge clk);
                #1;
                waited++;
            end
            if (!outValid || waited != 0) begin
                $display("timeout, outValid not high one cycle after issue (%0d extra)", waited);
                testErrors++;
            end else begin
                checkVal("opA", expA, opA);
                // opB only carries meaning for register-register ops
                if (expRtype) checkVal("opB", expB, opB);
                checkVal("storeData", expS, storeData);
                checkVal("imm", expImm, imm);
                checkVal("destEn", expEn, destEn);
                checkVal("destFp", expFp, destFp);
                checkVal("illegal", expIll, illegal);
                if (expEn) checkVal("destAddr", expDest, destAddr);
            end
        end
    endtask

    task automatic issueRtype(input logic [4:0] rs, rt, rd, input logic v, s, we, wf,
                              input logic [4:0] wa);
        logic [31:0] r;
        r = nextRand();
        applyCycle({`OP_RTYPE, rs, rt, rd, r[10:0]}, v, s, we, wf, wa, nextRand(),
                   rd != 0, 1'b0, 1'b0, rd);
    endtask

    task automatic finishTest(input string name);
        testsRun++;
        if (testErrors != 0) testsFailed++;
        errors += testErrors;
        $display("test %0d %s %s, %0d errors", testsRun, name,
                 (testErrors != 0) ? "failed" : "ok", testErrors);
        testErrors = 0;
    endtask

    // decode rows 0 to 6 and forwarding rows 7 to 11
    initial begin
        tbl[0]  = {`OP_RTYPE, 5'd1, 5'd2, 16'h1820, 2'b00, 5'd0, 1'b0, 3'b100, 5'd3};
        tbl[1]  = {`OP_ADDI, 5'd4, 5'd5, 16'hfff0, 2'b00, 5'd0, 1'b0, 3'b100, 5'd5};
        tbl[2]  = {`OP_LW, 5'd6, 5'd7, 16'h8000, 2'b00, 5'd0, 1'b0, 3'b100, 5'd7};
        tbl[3]  = {`OP_ADDI, 5'd8, 5'd0, 16'h0010, 2'b00, 5'd0, 1'b0, 3'b000, 5'd0};
        tbl[4]  = {`OP_FLW, 5'd8, 5'd0, 16'hff00, 2'b00, 5'd0, 1'b0, 3'b110, 5'd0};
        tbl[5]  = {`OP_FSW, 5'd9, 5'd10, 16'h7fff, 2'b00, 5'd0, 1'b0, 3'b000, 5'd0};
        // undefined opcode
        tbl[6]  = {6'h3f, 5'd11, 5'd12, 16'h1234, 2'b00, 5'd0, 1'b0, 3'b001, 5'd0};
        tbl[7]  = {`OP_RTYPE, 5'd13, 5'd14, 16'h7800, 2'b10, 5'd13, 1'b0, 3'b100, 5'd15};
        tbl[8]  = {`OP_FSW, 5'd1, 5'd20, 16'h0004, 2'b11, 5'd20, 1'b0, 3'b000, 5'd0};
        // write to r0 must not bypass
        tbl[9]  = {`OP_RTYPE, 5'd0, 5'd0, 16'h0800, 2'b10, 5'd0, 1'b0, 3'b100, 5'd1};
        tbl[10] = {`OP_RTYPE, 5'd22, 5'd17, 16'h2000, 2'b10, 5'd17, 1'b0, 3'b100, 5'd4};
        tbl[11] = {`OP_FLW, 5'd3, 5'd0, 16'h0000, 2'b11, 5'd0, 1'b0, 3'b110, 5'd0};
    end

    initial begin
        logic [31:0] r;
        rngState   = 32'hbee1eb35;
        rstN       = 1'b0;
        instr      = '0;
        instrValid = 1'b0;
        stall      = 1'b0;
        wbEn       = 1'b0;
        wbFp       = 1'b0;
        wbAddr     = '0;
        wbData     = '0;
        expValid   = 1'b0;
        errors     = 0;
        testErrors = 0;
        testsRun   = 0;
        testsFailed = 0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            shInt[i] = '0;
            shFp[i]  = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        rstN = 1'b1;

        // reset values and then a zero read of every register
        checkVal("outValid", 32'h0, outValid);
        checkVal("destEn", 32'h0, destEn);
        checkVal("destFp", 32'h0, destFp);
        checkVal("illegal", 32'h0, illegal);
        checkVal("opA", 32'h0, opA);
        checkVal("opB", 32'h0, opB);
        checkVal("storeData", 32'h0, storeData);
        checkVal("imm", 32'h0, imm);
        checkVal("destAddr", 32'h0, destAddr);
        for (int i = 0; i < 32; i++) issueRtype(i, i, 0, 1'b1, 1'b0, 1'b0, 1'b0, 0);
        finishTest("reset");

        // r0 included and its write must vanish
        for (int i = 0; i < 32; i++) applyCycle('0, 0, 0, 1, 0, i, nextRand(), 0, 0, 0, 0);
        for (int i = 0; i < 32; i++) applyCycle('0, 0, 0, 1, 1, i, nextRand(), 0, 0, 0, 0);
        for (int i = 0; i < 32; i++) issueRtype(i, 31 - i, i, 1'b1, 1'b0, 1'b0, 1'b0, 0);
        finishTest("fill and read back");

        for (int i = 0; i < 12; i++) begin
            applyCycle({tbl[i].op, tbl[i].rs, tbl[i].rt, tbl[i].immF}, 1'b1, tbl[i].stall,
                       tbl[i].wbEnFp[1], tbl[i].wbEnFp[0], tbl[i].wbAddr, nextRand(),
                       tbl[i].enFpIll[2], tbl[i].enFpIll[1], tbl[i].enFpIll[0], tbl[i].dest);
            if (i == 6) finishTest("decode");
        end
        finishTest("forwarding");

        // writes to int r5, int r6, fp r5, fp r6 while held
        issueRtype(5, 6, 7, 1'b1, 1'b0, 1'b0, 1'b0, 0);
        for (int c = 0; c < 4; c++) begin
            applyCycle(nextRand(), 1, 1, 1, c[1], 5 + c[0], nextRand(), 0, 0, 0, 0);
        end
        issueRtype(5, 6, 7, 1'b1, 1'b0, 1'b0, 1'b0, 0);
        finishTest("stall");

        // narrow address range so bypass and r0 hits are frequent
        for (int c = 0; c < 200; c++) begin
            r = nextRand();
            issueRtype(r[2:0], r[5:3], r[10:6], r[11], 1'b0, r[12], r[13], r[16:14]);
        end
        finishTest("random back to back");

        $display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+verilog
verilog/cpuPkg.sv
verilog/intRegFile.sv
verilog/fpRegFile.sv
verilog/instrDecode.sv
verilog/operandFetch.sv
sim/operandFetchTb.sv

//--- Bender.yml
package:
  name: operand_fetch

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cpuPkg.sv
      - verilog/intRegFile.sv
      - verilog/fpRegFile.sv
      - verilog/instrDecode.sv
      - verilog/operandFetch.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/operandFetchTb.sv
